//--- hw/spiMemory_params.svh
/* Width, depth and pin filter settings for the SPI memory.
   Include this header wherever one of these macros is needed. */

`ifndef SPI_MEMORY_PARAMS_SVH
`define SPI_MEMORY_PARAMS_SVH

// Storage geometry
`define MEM_ADDR_WIDTH 7
`define MEM_DATA_WIDTH 8
`define MEM_DEPTH 128

// Stable clk cycles before a synchronized pin level is accepted
`define SPI_WAIT_CYCLES 3

`endif

//--- hw/memPkg.sv
/* Storage types shared by the SPI controller and the byte memory. */
`default_nettype none

`include "spiMemory_params.svh"

package memPkg;

	typedef logic [`MEM_ADDR_WIDTH-1:0] memAddr;
	typedef logic [`MEM_DATA_WIDTH-1:0] memData;

	// One access to the memory, write when wrEn is high
	typedef struct packed {
		memAddr addr;
		memData wrData;
		logic wrEn;
	} memRequest;

endpackage

`default_nettype wire

//--- hw/spiPkg.sv
/* SPI protocol types: pin edge bundle, command/data frame and controller state.
   Referenced by scoped names from the conditioner, shift register and FSM. */
`default_nettype none

package spiPkg;

	// Read/write bit value that selects a read
	localparam logic rwRead = 1'b1;

	// Conditioned pin level plus its one-cycle edge pulses
	typedef struct packed {
		logic level;
		logic rise;
		logic fall;
	} pinEdges;

	// Command byte layout, address in the upper bits, rw in bit 0
	typedef struct packed {
		memPkg::memAddr addr;
		logic rw;
	} spiCommand;

	// Same shift register word, seen as command or as data
	typedef union packed {
		spiCommand cmd;
		memPkg::memData data;
	} spiFrame;

	typedef enum logic [2:0] {
		idle,
		getCommand,
		readLoad,
		readSend,
		writeGet,
		writeCommit,
		done
	} spiState;

endpackage

`default_nettype wire

//--- hw/inputConditioner.sv
/* Brings one asynchronous SPI pin into the clk domain.
   Gives a filtered level and one-cycle rising and falling pulses. */
`timescale 1ns/1ns
`default_nettype none

`include "spiMemory_params.svh"

module inputConditioner #(
	parameter int waitCycles = `SPI_WAIT_CYCLES
) (
	input logic clk,
	input logic rst,
	input logic pin,
	output spiPkg::pinEdges edges
);

	localparam int countWidth = $clog2(waitCycles + 1);

	logic syncFirst;
	logic syncSecond;
	logic [countWidth-1:0] stableCount;

	// --------------------------------------------------
	// Synchronizer and glitch filter
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			syncFirst <= 1'b0;
			syncSecond <= 1'b0;
			stableCount <= '0;
			edges <= '0;
		end else begin
			// Two flops against metastability
			syncFirst <= pin;
			syncSecond <= syncFirst;
			// Pulses last one cycle
			edges.rise <= 1'b0;
			edges.fall <= 1'b0;
			if (syncSecond == edges.level) begin
				// Glitch gone, start over
				stableCount <= '0;
			end else if (stableCount == countWidth'(waitCycles - 1)) begin
				// New level held long enough
				stableCount <= '0;
				edges.level <= syncSecond;
				edges.rise <= syncSecond;
				edges.fall <= ~syncSecond;
			end else begin
				stableCount <= stableCount + 1'b1;
			end
		end
	end

	// One level change per accepted edge, so never both pulses
	assert property (@(posedge clk) disable iff (rst) !(edges.rise && edges.fall))
		else $error("Rising and falling pulse together");

endmodule

`default_nettype wire

//--- hw/shiftRegister.sv
/* Shift register between the SPI pins and the controller.
   Shifts mosi in on sclk rise, loads read data, drives miso on sclk fall. */
`timescale 1ns/1ns
`default_nettype none

`include "spiMemory_params.svh"

module shiftRegister (
	input logic clk,
	input logic rst,
	input logic mosi,
	input logic sclkRise,
	input logic sclkFall,
	input logic load,
	input memPkg::memData parallelIn,
	input logic misoEnable,
	output spiPkg::spiFrame frame,
	output logic miso
);

	logic misoReg;

	// Parallel load wins over a shift in the same cycle
	always_ff @(posedge clk) begin
		if (load) begin
			frame.data <= parallelIn;
		end else if (sclkRise) begin
			// MSB first, new bit enters at bit 0
			frame.data <= {frame.data[`MEM_DATA_WIDTH-2:0], mosi};
		end
	end

	// Output stage, changes only on the falling sclk edge
	always_ff @(posedge clk) begin
		if (rst) begin
			misoReg <= 1'b0;
		end else if (sclkFall) begin
			misoReg <= frame.data[`MEM_DATA_WIDTH-1];
		end
	end

	// Low outside the read data phase
	assign miso = misoReg & misoEnable;

endmodule

`default_nettype wire

//--- hw/spiFsm.sv
/* Transaction controller for the SPI memory.
   Counts sclk rises, latches the command and runs one read or one write. */
`timescale 1ns/1ns
`default_nettype none

`include "spiMemory_params.svh"

module spiFsm (
	input logic clk,
	input logic rst,
	input logic csLevel,
	input logic sclkRise,
	input spiPkg::spiFrame frame,
	output logic load,
	output logic misoEnable,
	output memPkg::memRequest request
);

	localparam int countWidth = $clog2(`MEM_DATA_WIDTH) + 1;
	localparam logic [countWidth-1:0] byteBits = countWidth'(`MEM_DATA_WIDTH);

	spiPkg::spiState state;
	logic [countWidth-1:0] bitCount;
	logic latchCommand;
	memPkg::memAddr addrLatch;

	// Full command byte is in the frame
	assign latchCommand = !csLevel && (state == spiPkg::getCommand) && (bitCount == byteBits);

	// --------------------------------------------------
	// Address latch
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (latchCommand) begin
			addrLatch <= frame.cmd.addr;
		end
	end

	// --------------------------------------------------
	// State register and bit counter
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= spiPkg::idle;
			bitCount <= '0;
			load <= 1'b0;
		end else begin
			load <= 1'b0;
			if (csLevel) begin
				// Chip select high ends any transaction
				state <= spiPkg::idle;
				bitCount <= '0;
			end else begin
				case (state)
					spiPkg::idle: begin
						bitCount <= '0;
						state <= spiPkg::getCommand;
					end
					spiPkg::getCommand: begin
						if (latchCommand) begin
							bitCount <= '0;
							if (frame.cmd.rw == spiPkg::rwRead) begin
								state <= spiPkg::readLoad;
							end else begin
								state <= spiPkg::writeGet;
							end
						end else if (sclkRise) begin
							bitCount <= bitCount + 1'b1;
						end
					end
					// Memory reads the latched address this cycle
					spiPkg::readLoad: begin
						load <= 1'b1;
						state <= spiPkg::readSend;
					end
					spiPkg::readSend: begin
						if (bitCount == byteBits) begin
							state <= spiPkg::done;
						end else if (sclkRise) begin
							bitCount <= bitCount + 1'b1;
						end
					end
					spiPkg::writeGet: begin
						if (bitCount == byteBits) begin
							state <= spiPkg::writeCommit;
						end else if (sclkRise) begin
							bitCount <= bitCount + 1'b1;
						end
					end
					spiPkg::writeCommit: begin
						state <= spiPkg::done;
					end
					// Wait here for chip select
					spiPkg::done: begin
						state <= spiPkg::done;
					end
					default: begin
						state <= spiPkg::idle;
					end
				endcase
			end
		end
	end

	// Drive miso only while the read byte goes out
	assign misoEnable = (state == spiPkg::readSend);

	// Write data comes straight from the frame
	assign request.addr = addrLatch;
	assign request.wrData = frame.data;
	assign request.wrEn = (state == spiPkg::writeCommit);

	// Read load and write commit are separate phases
	assert property (@(posedge clk) disable iff (rst) !(load && request.wrEn))
		else $error("Load and write enable together");

	// Host sclk timing keeps chip select low through the commit cycle
	assert property (@(posedge clk) disable iff (rst) request.wrEn |-> !csLevel)
		else $error("Write with chip select high");

endmodule

`default_nettype wire

//--- hw/dataMemory.sv
/* Byte memory behind the SPI controller, registered read.
   Reset clears every entry to zero. */
`timescale 1ns/1ns
`default_nettype none

`include "spiMemory_params.svh"

module dataMemory (
	input logic clk,
	input logic rst,
	input memPkg::memRequest request,
	output memPkg::memData readData
);

	memPkg::memData mem [`MEM_DEPTH];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `MEM_DEPTH; i++) begin
				mem[i] <= '0;
			end
			readData <= '0;
		end else begin
			if (request.wrEn) begin
				mem[request.addr] <= request.wrData;
			end
			// Old contents on a same-address write
			readData <= mem[request.addr];
		end
	end

endmodule

`default_nettype wire

//--- hw/spiMemory.sv
/* Top level of the SPI mode 0 byte memory.
   Pin conditioners feed the shift register and controller, which access the memory. */
`timescale 1ns/1ns
`default_nettype none

module spiMemory (
	input logic clk,
	input logic rst,
	input logic sclkPin,
	input logic csPin,
	input logic mosiPin,
	output logic miso
);

	spiPkg::pinEdges mosiEdges;
	spiPkg::pinEdges sclkEdges;
	spiPkg::pinEdges csEdges;

	logic load;
	logic misoEnable;
	spiPkg::spiFrame frame;
	memPkg::memRequest request;
	memPkg::memData readData;

	// --------------------------------------------------
	// Pin conditioning
	// --------------------------------------------------
	inputConditioner mosiCond (
		.clk(clk),
		.rst(rst),
		.pin(mosiPin),
		.edges(mosiEdges)
	);

	inputConditioner sclkCond (
		.clk(clk),
		.rst(rst),
		.pin(sclkPin),
		.edges(sclkEdges)
	);

	inputConditioner csCond (
		.clk(clk),
		.rst(rst),
		.pin(csPin),
		.edges(csEdges)
	);

	// --------------------------------------------------
	// Datapath and control
	// --------------------------------------------------
	shiftRegister shiftRegister_i (
		.clk(clk),
		.rst(rst),
		.mosi(mosiEdges.level),
		.sclkRise(sclkEdges.rise),
		.sclkFall(sclkEdges.fall),
		.load(load),
		.parallelIn(readData),
		.misoEnable(misoEnable),
		.frame(frame),
		.miso(miso)
	);

	spiFsm spiFsm_i (
		.clk(clk),
		.rst(rst),
		.csLevel(csEdges.level),
		.sclkRise(sclkEdges.rise),
		.frame(frame),
		.load(load),
		.misoEnable(misoEnable),
		.request(request)
	);

	dataMemory dataMemory_i (
		.clk(clk),
		.rst(rst),
		.request(request),
		.readData(readData)
	);

endmodule

`default_nettype wire

//--- bench/spiMemoryTb.sv
/* Testbench for the SPI mode 0 byte memory. A bit-banged host applies a
   transaction table, a scoreboard models the memory, and miso is watched. */
`timescale 1ns/1ns
`default_nettype none

`include "spiMemory_params.svh"

module spiMemoryTb;

	// sclk half period in clk cycles
	localparam int halfClocks = 8;
	// Read/write bit value for a read command
	localparam logic readBit = 1'b1;

	typedef enum logic [1:0] {
		opWrite,
		opRead,
		opAbortedWrite
	} opKind;

	typedef struct packed {
		opKind kind;
		memPkg::memAddr addr;
		memPkg::memData data;
		logic [3:0] bitsBeforeAbort;
	} txnEntry;

	logic clk;
	logic rst;
	logic sclkPin;
	logic csPin;
	logic mosiPin;
	logic miso;

	txnEntry txnTable [$];
	memPkg::memData expectedMem [`MEM_DEPTH];
	logic usedAddr [`MEM_DEPTH];
	integer seed = 32'h9496;
	int cycleCount = 0;
	int timeoutLimit = 0;

	spiMemory spiMemory_i (
		.clk(clk),
		.rst(rst),
		.sclkPin(sclkPin),
		.csPin(csPin),
		.mosiPin(mosiPin),
		.miso(miso)
	);

	// 100 ns clk
	always #50 clk = ~clk;

	// Run limit, armed once the table size is known
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (timeoutLimit != 0 && cycleCount > timeoutLimit) begin
			$display("Timeout: transactions did not finish within %0d clk cycles", timeoutLimit);
			$display("Errors found");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	task automatic checkData(input memPkg::memData got, input memPkg::memData expected);
		if (got !== expected) begin
			$display("error at %0t: read byte %h, expected %h", $time, got, expected);
			$display("Errors found");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic checkIdle(input logic got);
		if (got !== 1'b0) begin
			$display("error at %0t: miso is %b outside read data, expected 0", $time, got);
			$display("Errors found");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// --------------------------------------------------
	// SPI host
	// --------------------------------------------------
	// Sampling on the falling clk edge, away from the driving edge
	task automatic waitHalfPeriod(input logic watchMiso);
		repeat (halfClocks) begin
			@(negedge clk);
			if (watchMiso) begin
				checkIdle(miso);
			end
		end
	endtask

	// One sclk cycle, low half then high half
	task automatic clockBit(input logic bitValue, input logic watchLow,
			input logic watchHigh, output logic sampled);
		// mosi changes only while sclk is low
		@(posedge clk);
		sclkPin <= 1'b0;
		mosiPin <= bitValue;
		waitHalfPeriod(watchLow);
		// miso settled by the end of the low half
		sampled = miso;
		@(posedge clk);
		sclkPin <= 1'b1;
		waitHalfPeriod(watchHigh);
	endtask

	task automatic applyTransaction(input txnEntry entry);
		logic [`MEM_DATA_WIDTH-1:0] command;
		memPkg::memData readByte;
		logic sampled;
		logic isRead;
		isRead = (entry.kind == opRead);
		// Address first, rw bit last
		command = {entry.addr, isRead ? readBit : ~readBit};
		@(posedge clk);
		csPin <= 1'b0;
		sclkPin <= 1'b0;
		mosiPin <= 1'b0;
		waitHalfPeriod(1'b1);
		// Command byte, miso must stay low
		// Last high half of a read skipped, the data phase starts there
		for (int i = `MEM_DATA_WIDTH - 1; i >= 0; i--) begin
			clockBit(command[i], 1'b1, !(isRead && i == 0), sampled);
		end
		case (entry.kind)
			opWrite: begin
				for (int i = `MEM_DATA_WIDTH - 1; i >= 0; i--) begin
					clockBit(entry.data[i], 1'b1, 1'b1, sampled);
				end
				expectedMem[entry.addr] = entry.data;
			end
			opAbortedWrite: begin
				// Partial byte, then chip select rises
				for (int i = 0; i < entry.bitsBeforeAbort; i++) begin
					clockBit(entry.data[`MEM_DATA_WIDTH - 1 - i], 1'b1, 1'b1, sampled);
				end
			end
			default: begin
				for (int i = `MEM_DATA_WIDTH - 1; i >= 0; i--) begin
					clockBit(1'b0, 1'b0, 1'b0, sampled);
					readByte[i] = sampled;
				end
				checkData(readByte, expectedMem[entry.addr]);
			end
		endcase
		// Mode 0 idle level, then deselect
		@(posedge clk);
		sclkPin <= 1'b0;
		waitHalfPeriod(1'b1);
		@(posedge clk);
		csPin <= 1'b1;
		mosiPin <= 1'b0;
		waitHalfPeriod(1'b1);
		waitHalfPeriod(1'b1);
	endtask

	// --------------------------------------------------
	// Transaction table
	// --------------------------------------------------
	task automatic addEntry(input opKind kind, input memPkg::memAddr addr,
			input memPkg::memData data, input logic [3:0] bitsBeforeAbort);
		txnEntry entry;
		entry.kind = kind;
		entry.addr = addr;
		entry.data = data;
		entry.bitsBeforeAbort = bitsBeforeAbort;
		txnTable.push_back(entry);
	endtask

	// Random address not used by any other entry
	task automatic pickFreshAddress(output memPkg::memAddr addr);
		logic [31:0] randomWord;
		do begin
			randomWord = $random(seed);
			addr = randomWord[`MEM_ADDR_WIDTH-1:0];
		end while (usedAddr[addr]);
		usedAddr[addr] = 1'b1;
	endtask

	task automatic fillTable();
		memPkg::memAddr randomAddr [4];
		logic [31:0] randomWord;
		for (int i = 0; i < `MEM_DEPTH; i++) begin
			usedAddr[i] = 1'b0;
		end
		usedAddr[7'h00] = 1'b1;
		usedAddr[7'h05] = 1'b1;
		usedAddr[7'h12] = 1'b1;
		usedAddr[7'h33] = 1'b1;
		usedAddr[7'h44] = 1'b1;
		usedAddr[7'h7f] = 1'b1;
		// Never written, reset value
		addEntry(opRead, 7'h05, 8'h00, 4'd0);
		addEntry(opRead, 7'h00, 8'h00, 4'd0);
		// Write then read back, both ends of the range
		addEntry(opWrite, 7'h12, 8'hA5, 4'd0);
		addEntry(opRead, 7'h12, 8'h00, 4'd0);
		addEntry(opWrite, 7'h7f, 8'h81, 4'd0);
		addEntry(opRead, 7'h7f, 8'h00, 4'd0);
		// Distinct random addresses, aliasing check
		for (int k = 0; k < 4; k++) begin
			pickFreshAddress(randomAddr[k]);
			randomWord = $random(seed);
			addEntry(opWrite, randomAddr[k], randomWord[`MEM_DATA_WIDTH-1:0], 4'd0);
		end
		for (int k = 0; k < 4; k++) begin
			addEntry(opRead, randomAddr[k], 8'h00, 4'd0);
		end
		// Overwrite
		addEntry(opWrite, 7'h33, 8'h5A, 4'd0);
		addEntry(opWrite, 7'h33, 8'hC3, 4'd0);
		addEntry(opRead, 7'h33, 8'h00, 4'd0);
		// Cut short, old value must survive
		addEntry(opWrite, 7'h44, 8'h96, 4'd0);
		randomWord = $random(seed);
		addEntry(opAbortedWrite, 7'h44, randomWord[`MEM_DATA_WIDTH-1:0], 4'd3);
		addEntry(opRead, 7'h44, 8'h00, 4'd0);
		addEntry(opAbortedWrite, 7'h05, 8'hFF, 4'd7);
		addEntry(opRead, 7'h05, 8'h00, 4'd0);
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		clk = 1'b0;
		rst = 1'b1;
		sclkPin = 1'b0;
		csPin = 1'b1;
		mosiPin = 1'b0;
		// Memory is all zeros after reset
		for (int i = 0; i < `MEM_DEPTH; i++) begin
			expectedMem[i] = '0;
		end
		fillTable();
		// Worst case 18 bit times of 16 clk cycles per entry
		timeoutLimit = txnTable.size() * 18 * 16 + 200;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		// Deselected, miso low
		waitHalfPeriod(1'b1);
		waitHalfPeriod(1'b1);
		foreach (txnTable[n]) begin
			applyTransaction(txnTable[n]);
		end
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
+incdir+hw
hw/memPkg.sv
hw/spiPkg.sv
hw/inputConditioner.sv
hw/shiftRegister.sv
hw/spiFsm.sv
hw/dataMemory.sv
hw/spiMemory.sv
bench/spiMemoryTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the SPI memory testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module spiMemoryTb -f compile.f \
	-o spiMemorySim || exit 1
simOutput=$(./obj_dir/spiMemorySim)
echo "$simOutput"
echo "$simOutput" | grep -qx "No errors" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
